// File: source/fft_macros.svh
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// --------------------
// Sample format
// --------------------
`define FFT_DATA_WIDTH  16  // Bits per real or imag part

// --------------------
// Transform size
// --------------------
`define FFT_POINTS      16  // Points per frame
`define FFT_LOG2_POINTS 4   // Index width within a frame

// --------------------
// Twiddle format, Q1.15
// --------------------
`define FFT_TW_WIDTH    16  // Bits per twiddle component
`define FFT_TW_FRAC     15  // Fraction bits

`endif

// File: source/fft_pkg.sv
`default_nettype none

`include "fft_macros.svh"

package fft_pkg;

    // One component of a complex sample
    typedef logic signed [`FFT_DATA_WIDTH-1:0] sample_t;

    // One twiddle component in Q1.15
    typedef logic signed [`FFT_TW_WIDTH-1:0] twiddle_t;

    // Position within a frame
    typedef logic [`FFT_LOG2_POINTS-1:0] sample_index_t;

    // Complex sample
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // Word passed between all datapath blocks
    typedef struct packed {
        logic  valid;  // Sample present this cycle
        cplx_t data;
    } stream_t;

endpackage

`default_nettype wire

// File: source/sdf_stage_counter.sv
`timescale 1ns/100ps
`default_nettype none

// Counts valid samples entering a stage, modulo M
module sdf_stage_counter #(
    parameter int M = 16
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   sample_valid,
    output fft_pkg::sample_index_t count  // Index of the current input sample
);

    localparam fft_pkg::sample_index_t LAST = fft_pkg::sample_index_t'(M - 1);

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (sample_valid) begin
            if (count == LAST) begin
                count <= '0;  // Frame boundary
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sdf_butterfly.sv
`timescale 1ns/100ps
`default_nettype none

// Radix-2 SDF butterfly with DEPTH-word feedback
// Output lags input by DEPTH + 1
module sdf_butterfly #(
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             rst,
    input  fft_pkg::stream_t bf_in,
    input  logic             bf_phase,  // High while the second operand arrives
    output fft_pkg::stream_t bf_out
);

    localparam int W = $bits(fft_pkg::sample_t);

    fft_pkg::stream_t line [DEPTH];  // Feedback delay, valid travels along
    fft_pkg::stream_t head;          // Oldest word, first operand
    fft_pkg::cplx_t   half_sum;
    fft_pkg::cplx_t   half_diff;

    // (a +/- b) / 2, half LSB added before the shift
    function automatic fft_pkg::sample_t half_of(
        input fft_pkg::sample_t a,
        input fft_pkg::sample_t b,
        input logic             sub
    );
        logic signed [W:0] total;
        total = sub ? a - b : a + b;  // One guard bit
        total = total + 1;
        return total[W:1];
    endfunction

    assign head = line[DEPTH-1];

    always_comb begin
        half_sum.re  = half_of(head.data.re, bf_in.data.re, 1'b0);
        half_sum.im  = half_of(head.data.im, bf_in.data.im, 1'b0);
        half_diff.re = half_of(head.data.re, bf_in.data.re, 1'b1);
        half_diff.im = half_of(head.data.im, bf_in.data.im, 1'b1);
    end

    // --------------------
    // Feedback and output
    // --------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                line[i] <= '0;
            end
            bf_out <= '0;
        end else begin
            for (int i = 1; i < DEPTH; i++) begin
                line[i] <= line[i-1];
            end
            if (bf_phase) begin
                line[0] <= '{valid: bf_in.valid, data: half_diff};  // Drained next half
                bf_out  <= '{valid: head.valid, data: half_sum};
            end else begin
                line[0] <= bf_in;  // Fill with first operand
                bf_out  <= head;   // Previous differences out
            end
        end
    end

endmodule

`default_nettype wire

// File: source/twiddle_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

// W16 twiddle table and complex multiply, 2-cycle latency
module twiddle_multiplier (
    input  logic                   clock,
    input  logic                   rst,
    input  fft_pkg::stream_t       tw_in,
    input  fft_pkg::sample_index_t tw_index,  // BF-II output position
    output fft_pkg::stream_t       tw_out
);

    localparam int PW   = `FFT_DATA_WIDTH + `FFT_TW_WIDTH;  // Product width
    localparam int DMAX = 2 ** (`FFT_DATA_WIDTH - 1) - 1;

    logic [3:0]          exponent;  // k of W16^k, up to 9
    fft_pkg::twiddle_t   w_re;
    fft_pkg::twiddle_t   w_im;
    logic signed [PW-1:0] p_rr;
    logic signed [PW-1:0] p_ii;
    logic signed [PW-1:0] p_ri;
    logic signed [PW-1:0] p_ir;
    logic                valid_d;
    logic signed [PW:0]  acc_re;
    logic signed [PW:0]  acc_im;

    // Drop Q1.15 fraction with rounding, clamp to sample range
    function automatic fft_pkg::sample_t round_sat(input logic signed [PW:0] acc);
        logic signed [PW:0] shifted;
        shifted = (acc + (1 <<< (`FFT_TW_FRAC - 1))) >>> `FFT_TW_FRAC;
        if (shifted > DMAX) begin
            return fft_pkg::sample_t'(DMAX);
        end else if (shifted < -DMAX - 1) begin
            return fft_pkg::sample_t'(-DMAX - 1);
        end
        return shifted[`FFT_DATA_WIDTH-1:0];
    endfunction

    // --------------------
    // Exponent per position
    // --------------------
    // Position bits {k1, k2, n3}, exponent n3 * (k1 + 2 * k2)
    always_comb begin
        case (tw_index)
            4'd5, 4'd10:  exponent = 4'd2;
            4'd6:         exponent = 4'd4;
            4'd7, 4'd14:  exponent = 4'd6;
            4'd9:         exponent = 4'd1;
            4'd11, 4'd13: exponent = 4'd3;
            4'd15:        exponent = 4'd9;
            default:      exponent = 4'd0;  // n3 = 0 or first quarter
        endcase
    end

    // W16^k = cos - j sin, Q1.15
    always_comb begin
        case (exponent)
            4'd1:    {w_re, w_im} = {16'sd30274, -16'sd12540};
            4'd2:    {w_re, w_im} = {16'sd23170, -16'sd23170};
            4'd3:    {w_re, w_im} = {16'sd12540, -16'sd30274};
            4'd4:    {w_re, w_im} = {16'sd0, -16'sd32767};
            4'd6:    {w_re, w_im} = {-16'sd23170, -16'sd23170};
            4'd9:    {w_re, w_im} = {-16'sd30274, 16'sd12540};
            default: {w_re, w_im} = {16'sd32767, 16'sd0};  // Unity, near enough
        endcase
    end

    // Cycle 1, four partial products
    always_ff @(posedge clock) begin
        p_rr <= tw_in.data.re * w_re;
        p_ii <= tw_in.data.im * w_im;
        p_ri <= tw_in.data.re * w_im;
        p_ir <= tw_in.data.im * w_re;
    end

    assign acc_re = p_rr - p_ii;
    assign acc_im = p_ri + p_ir;

    // Cycle 2, round and register
    always_ff @(posedge clock) begin
        if (rst) begin
            valid_d <= 1'b0;
            tw_out  <= '0;
        end else begin
            valid_d <= tw_in.valid;
            tw_out  <= '{valid: valid_d,
                         data: '{re: round_sat(acc_re), im: round_sat(acc_im)}};
        end
    end

endmodule

`default_nettype wire

// File: source/sdf_r22_stage.sv
`timescale 1ns/100ps
`default_nettype none

// One radix-2^2 SDF stage over M points
// BF-I, -j on the last quarter, BF-II, then twiddle when M > 4
module sdf_r22_stage #(
    parameter int M = 16  // Power of four
) (
    input  logic             clock,
    input  logic             rst,
    input  fft_pkg::stream_t stage_in,
    output fft_pkg::stream_t stage_out
);

    localparam int LOG_M   = $clog2(M);
    localparam int D1      = M / 2;  // BF-I feedback depth
    localparam int D2      = M / 4;  // BF-II feedback depth
    localparam int IDX_LEN = (M > 4) ? D1 + D2 + 2 : D1 + 1;

    fft_pkg::sample_index_t count;                // Index of the sample entering now
    fft_pkg::sample_index_t idx_line [IDX_LEN];   // Index follows the data
    fft_pkg::sample_index_t idx_a;                // Aligned with bf1_out
    fft_pkg::stream_t       bf1_out;
    fft_pkg::stream_t       rot_out;
    fft_pkg::stream_t       bf2_out;
    logic                   rotate;

    sdf_stage_counter #(
        .M (M)
    ) u_counter (
        .clock        (clock),
        .rst          (rst),
        .sample_valid (stage_in.valid),
        .count        (count)
    );

    // --------------------
    // Index delay line
    // --------------------
    // Shifts every clock so drained samples keep their index
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < IDX_LEN; i++) begin
                idx_line[i] <= '0;
            end
        end else begin
            idx_line[0] <= count;
            for (int i = 1; i < IDX_LEN; i++) begin
                idx_line[i] <= idx_line[i-1];
            end
        end
    end

    assign idx_a  = idx_line[D1];  // D1 + 1 cycles behind the input
    assign rotate = idx_a[LOG_M-1] & idx_a[LOG_M-2];  // Fourth quarter

    sdf_butterfly #(
        .DEPTH (D1)
    ) u_bf1 (
        .clock    (clock),
        .rst      (rst),
        .bf_in    (stage_in),
        .bf_phase (count[LOG_M-1]),  // Second half pairs with first
        .bf_out   (bf1_out)
    );

    // Trivial -j, swap and negate
    always_comb begin
        rot_out = bf1_out;
        if (rotate) begin
            rot_out.data.re = bf1_out.data.im;
            rot_out.data.im = -bf1_out.data.re;
        end
    end

    sdf_butterfly #(
        .DEPTH (D2)
    ) u_bf2 (
        .clock    (clock),
        .rst      (rst),
        .bf_in    (rot_out),
        .bf_phase (idx_a[LOG_M-2]),  // Odd quarter of each half
        .bf_out   (bf2_out)
    );

    // --------------------
    // Inter-stage twiddle
    // --------------------
    if (M > 4) begin : g_twiddle
        twiddle_multiplier u_twiddle (
            .clock    (clock),
            .rst      (rst),
            .tw_in    (bf2_out),
            .tw_index (idx_line[IDX_LEN-1]),  // Aligned with bf2_out
            .tw_out   (stage_out)
        );
    end else begin : g_last
        assign stage_out = bf2_out;  // Final stage, all twiddles are 1
    end

endmodule

`default_nettype wire

// File: source/fft16_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

// 16-point radix-2^2 SDF FFT
// Natural order in, bit-reversed order out, scaled by 1/16
module fft16_top (
    input  logic             clock,
    input  logic             rst,
    input  fft_pkg::stream_t in_stream,   // One frame = 16 back-to-back valid samples
    output fft_pkg::stream_t out_stream   // Bin bitreverse4(p) at position p
);

    fft_pkg::stream_t s16_out;  // After the M=16 stage, twiddled
    fft_pkg::stream_t s4_out;   // After the M=4 stage

    // --------------------
    // Stage chain
    // --------------------
    sdf_r22_stage #(
        .M (`FFT_POINTS)
    ) u_stage16 (
        .clock     (clock),
        .rst       (rst),
        .stage_in  (in_stream),
        .stage_out (s16_out)
    );

    // Last stage, no twiddle needed
    sdf_r22_stage #(
        .M (`FFT_POINTS / 4)
    ) u_stage4 (
        .clock     (clock),
        .rst       (rst),
        .stage_in  (s16_out),
        .stage_out (s4_out)
    );

    // Output register
    always_ff @(posedge clock) begin
        if (rst) begin
            out_stream <= '0;
        end else begin
            out_stream <= s4_out;
        end
    end

endmodule

`default_nettype wire

// File: verif/fft16_properties.sv
`timescale 1ns/100ps
`default_nettype none

// Output stream protocol checks on fft16_top
module fft16_properties (
    input logic             clock,
    input logic             rst,
    input fft_pkg::stream_t out_stream
);

    fft_pkg::sample_index_t run_pos;  // Position within the current output frame

    always_ff @(posedge clock) begin
        if (rst) begin
            run_pos <= '0;
        end else if (out_stream.valid) begin
            run_pos <= run_pos + 1'b1;  // Wraps every 16
        end
    end

    // --------------------
    // Output valid
    // --------------------
    a_idle_after_reset: assert property (@(posedge clock) rst |=> !out_stream.valid)
        else $error("Output valid high in the cycle after reset");

    a_valid_known: assert property (@(posedge clock) disable iff (rst)
        !$isunknown(out_stream.valid))
        else $error("Output valid is unknown");

    // A frame is 16 in a row; back-to-back frames may stretch the run
    a_frame_length: assert property (@(posedge clock) disable iff (rst)
        $rose(out_stream.valid) |-> out_stream.valid [*16])
        else $error("Output frame shorter than 16 samples");

    a_frame_end: assert property (@(posedge clock) disable iff (rst)
        $fell(out_stream.valid) |-> run_pos == '0)
        else $error("Output valid dropped inside a frame");

endmodule

bind fft16_top fft16_properties u_properties (
    .clock      (clock),
    .rst        (rst),
    .out_stream (out_stream)
);

`default_nettype wire

// File: verif/fft16_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_macros.svh"

module fft16_tb;

    localparam int  N          = `FFT_POINTS;
    localparam int  TOL        = 3;      // LSB per component
    localparam int  NUM_RANDOM = 8;      // Back-to-back random frames
    localparam int  NUM_FRAMES = NUM_RANDOM + 4;
    localparam int  NUM_TESTS  = 6;
    localparam int  IDLE_CHECK = 60;     // Cycles watched with no input
    localparam int  GAP_CYCLES = 300;    // Idle gap before the last frame
    localparam int  LIMIT      = 16000;  // Random sample magnitude
    localparam real PERIOD     = 20.0;
    localparam real PI         = 3.14159265358979;
    localparam real WATCHDOG_NS =
        (NUM_FRAMES * N + NUM_TESTS * 40 + IDLE_CHECK + GAP_CYCLES) * PERIOD * 2.0;

    logic                   clock;
    logic                   rst;
    fft_pkg::stream_t       in_stream;
    fft_pkg::stream_t       out_stream;

    int                     frame_re [N];      // Frame being sent
    int                     frame_im [N];
    fft_pkg::cplx_t         expected_q [$];    // Bins in output order
    fft_pkg::sample_index_t out_pos = '0;      // Position within output frame
    logic                   prev_valid = 1'b0;
    int                     pass_count = 0;
    int                     fail_count = 0;
    integer                 seed;

    fft16_top UUT (
        .clock      (clock),
        .rst        (rst),
        .in_stream  (in_stream),
        .out_stream (out_stream)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2.0) clock = ~clock;

    // --------------------
    // Reference model
    // --------------------
    function automatic fft_pkg::sample_index_t bitrev4(input fft_pkg::sample_index_t p);
        return {p[0], p[1], p[2], p[3]};
    endfunction

    // Bin k of the DFT of frame_re/frame_im, scaled by 1/N and rounded
    function automatic fft_pkg::cplx_t reference_dft(input int k);
        real            acc_re;
        real            acc_im;
        real            theta;
        fft_pkg::cplx_t bin;
        acc_re = 0.0;
        acc_im = 0.0;
        for (int n = 0; n < N; n++) begin
            theta  = 2.0 * PI * k * n / N;  // e^-j theta
            acc_re = acc_re + frame_re[n] * $cos(theta) + frame_im[n] * $sin(theta);
            acc_im = acc_im + frame_im[n] * $cos(theta) - frame_re[n] * $sin(theta);
        end
        bin.re = fft_pkg::sample_t'(int'(acc_re / N));
        bin.im = fft_pkg::sample_t'(int'(acc_im / N));
        return bin;
    endfunction

    // --------------------
    // Checks
    // --------------------
    task automatic check_sample(input fft_pkg::cplx_t got, input fft_pkg::cplx_t exp,
                                input fft_pkg::sample_index_t pos);
        int d_re;
        int d_im;
        d_re = int'(got.re) - int'(exp.re);
        d_im = int'(got.im) - int'(exp.im);
        if (d_re < 0) d_re = -d_re;
        if (d_im < 0) d_im = -d_im;
        if (d_re > TOL || d_im > TOL) begin
            $display("ERROR @ %0t ns: position %0d got (%0d, %0d), expected (%0d, %0d)",
                     $time, pos, got.re, got.im, exp.re, exp.im);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_count(input fft_pkg::sample_index_t got,
                               input fft_pkg::sample_index_t exp);
        if (got != exp) begin
            $display("ERROR @ %0t ns: output frame broke at position %0d, expected %0d",
                     $time, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // Outputs sampled on the falling edge, away from register updates
    always @(negedge clock) begin
        if (!rst) begin
            if (out_stream.valid) begin
                if (expected_q.size() == 0) begin
                    $display("ERROR @ %0t ns: an output sample came with no frame pending",
                             $time);
                    fail_count++;
                end else begin
                    check_sample(out_stream.data, expected_q.pop_front(), out_pos);
                end
                out_pos = out_pos + 1'b1;
            end else if (prev_valid) begin
                check_count(out_pos, '0);  // Run must end on a frame boundary
            end
            prev_valid = out_stream.valid;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic send_frame();
        for (int p = 0; p < N; p++) begin
            expected_q.push_back(reference_dft(bitrev4(fft_pkg::sample_index_t'(p))));
        end
        for (int n = 0; n < N; n++) begin
            @(posedge clock);
            #2;
            in_stream.valid   = 1'b1;
            in_stream.data.re = fft_pkg::sample_t'(frame_re[n]);
            in_stream.data.im = fft_pkg::sample_t'(frame_im[n]);
        end
    endtask

    task automatic idle(input int cycles);
        @(posedge clock);
        #2;
        in_stream = '0;
        repeat (cycles) @(posedge clock);
    endtask

    task automatic wait_drain();
        idle(0);
        while (expected_q.size() != 0) @(negedge clock);
        repeat (2) @(negedge clock);  // Let the frame-end check run
    endtask

    task automatic fill_random();
        for (int n = 0; n < N; n++) begin
            frame_re[n] = $random(seed) % (LIMIT + 1);
            frame_im[n] = $random(seed) % (LIMIT + 1);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("Test %0s: done, %0d errors", name, fail_count - fails_before);
    endtask

    initial begin
        int fails_before;
        seed      = 58724;
        rst       = 1'b1;
        in_stream = '0;
        repeat (2) @(posedge clock);
        #2;
        rst = 1'b0;

        fails_before = fail_count;  // No input, monitor flags any valid
        repeat (IDLE_CHECK) @(posedge clock);
        report_test("idle", fails_before);

        fails_before = fail_count;
        for (int n = 0; n < N; n++) begin
            frame_re[n] = (n == 0) ? 8000 : 0;
            frame_im[n] = (n == 0) ? -4000 : 0;
        end
        send_frame();
        wait_drain();
        report_test("impulse", fails_before);

        fails_before = fail_count;
        for (int n = 0; n < N; n++) begin
            frame_re[n] = 5000;
            frame_im[n] = 1200;
        end
        send_frame();
        wait_drain();
        report_test("constant", fails_before);

        fails_before = fail_count;  // Tone at bin 3, lands at position 12
        for (int n = 0; n < N; n++) begin
            frame_re[n] = int'(12000.0 * $cos(2.0 * PI * 3 * n / N));
            frame_im[n] = int'(12000.0 * $sin(2.0 * PI * 3 * n / N));
        end
        send_frame();
        wait_drain();
        report_test("tone", fails_before);

        fails_before = fail_count;
        for (int f = 0; f < NUM_RANDOM; f++) begin
            fill_random();
            send_frame();
        end
        wait_drain();
        report_test("random", fails_before);

        fails_before = fail_count;
        idle(GAP_CYCLES);
        fill_random();
        send_frame();
        wait_drain();
        report_test("gap", fails_before);

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0.0f ns, the output never fully arrived",
                 WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/fft_pkg.sv
source/sdf_stage_counter.sv
source/sdf_butterfly.sv
source/twiddle_multiplier.sv
source/sdf_r22_stage.sv
source/fft16_top.sv
verif/fft16_properties.sv
verif/fft16_tb.sv

// File: Bender.yml
package:
  name: fft16

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fft_pkg.sv
      - source/sdf_stage_counter.sv
      - source/sdf_butterfly.sv
      - source/twiddle_multiplier.sv
      - source/sdf_r22_stage.sv
      - source/fft16_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/fft16_properties.sv
      - verif/fft16_tb.sv
